// ==== source/arm_exec_config.svh ====
`ifndef ARM_EXEC_CONFIG_SVH
`define ARM_EXEC_CONFIG_SVH

// Data path and instruction width
`define ARM_WORD_W 32

// Architectural registers, 4-bit address
`define ARM_NUM_REGS 16

// Data memory depth in words, word addressed by result bits 7:2
`define ARM_DMEM_WORDS 64

`endif

// ==== source/arm_pkg.sv ====
`include "arm_exec_config.svh"

package arm_pkg;

  typedef logic [$clog2(`ARM_NUM_REGS)-1:0] reg_addr_t;

  typedef enum logic [2:0] {
    CLS_DP_REG = 3'b000,
    CLS_DP_IMM = 3'b001,
    CLS_LS     = 3'b010,
    CLS_BRANCH = 3'b101
  } inst_class_e;

  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL
  } cond_e;

  typedef enum logic [3:0] {
    OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD, OP_ADC, OP_SBC, OP_RSC,
    OP_TST, OP_TEQ, OP_CMP, OP_CMN, OP_ORR, OP_MOV, OP_BIC, OP_MVN
  } alu_op_e;

  // Data processing view, also used for branches
  typedef struct packed {
    cond_e       cond;
    inst_class_e cls;
    alu_op_e     opcode;
    logic        s;
    reg_addr_t   rn;
    reg_addr_t   rd;
    logic [11:0] operand;
  } dp_view_t;

  // Load/store view
  typedef struct packed {
    cond_e       cond;
    inst_class_e cls;
    logic        p;
    logic        u;
    logic        b;
    logic        w;
    logic        l;
    reg_addr_t   rn;
    reg_addr_t   rd;
    logic [11:0] offset12;
  } ls_view_t;

  typedef union packed {
    dp_view_t dp;
    ls_view_t ls;
  } arm_inst_u;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    logic                   valid;
    arm_inst_u              inst;
    logic [`ARM_WORD_W-1:0] ra_data;
    logic [`ARM_WORD_W-1:0] rb_data;
    reg_addr_t              ra_addr;
    reg_addr_t              rb_addr;
  } ex_req_t;

  typedef struct packed {
    logic                   valid;
    logic                   do_write;
    logic                   is_load;
    logic                   is_store;
    reg_addr_t              rd;
    logic [`ARM_WORD_W-1:0] result;
    logic [`ARM_WORD_W-1:0] store_data;
  } ex_res_t;

  typedef struct packed {
    logic                   en;
    reg_addr_t              addr;
    logic [`ARM_WORD_W-1:0] data;
  } wb_t;

endpackage

// ==== source/operand_unit.sv ====
`timescale 1ns/1ps
`include "arm_exec_config.svh"

module operand_unit import arm_pkg::*; (
    input  arm_inst_u              inst_i
  , input  logic [`ARM_WORD_W-1:0] rm_i
  , output logic [`ARM_WORD_W-1:0] op2_o
);

  localparam int W = `ARM_WORD_W;

  localparam logic [1:0] SH_LSL = 2'b00;
  localparam logic [1:0] SH_LSR = 2'b01;
  localparam logic [1:0] SH_ASR = 2'b10;

  logic [3:0]     rot;
  logic [7:0]     imm8;
  logic [4:0]     shamt;
  logic [5:0]     shamt_ext;
  logic [1:0]     sh_type;
  logic [W-1:0]   imm_ext;
  logic [2*W-1:0] imm_dbl;
  logic [2*W-1:0] rm_dbl;

  assign rot     = inst_i.dp.operand[11:8];
  assign imm8    = inst_i.dp.operand[7:0];
  assign shamt   = inst_i.dp.operand[11:7];
  assign sh_type = inst_i.dp.operand[6:5];

  // Rotate right by doubling the word and shifting the pair
  assign imm_ext = {{(W-8){1'b0}}, imm8};
  assign imm_dbl = {imm_ext, imm_ext} >> {rot, 1'b0};
  assign rm_dbl  = {rm_i, rm_i} >> shamt;

  // LSR #0 and ASR #0 mean a shift by 32
  assign shamt_ext = (shamt == 5'd0) ? 6'd32 : {1'b0, shamt};

  always_comb begin
    case (inst_i.dp.cls)
      CLS_DP_IMM: op2_o = imm_dbl[W-1:0];
      CLS_DP_REG: begin
        case (sh_type)
          SH_LSL:  op2_o = rm_i << shamt;
          SH_LSR:  op2_o = rm_i >> shamt_ext;
          SH_ASR:  op2_o = $signed(rm_i) >>> shamt_ext;
          // ROR, amount 0 leaves rm as is
          default: op2_o = rm_dbl[W-1:0];
        endcase
      end
      CLS_LS:     op2_o = {{(W-12){1'b0}}, inst_i.ls.offset12};
      default:    op2_o = '0;
    endcase
  end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps
`include "arm_exec_config.svh"

module alu import arm_pkg::*; (
    input  logic                   clk_i
  , input  logic                   reset_i
  , input  alu_op_e                op_i
  , input  logic [`ARM_WORD_W-1:0] a_i
  , input  logic [`ARM_WORD_W-1:0] b_i
  , input  cond_e                  cond_i
  , input  logic                   set_flags_i
  , output logic [`ARM_WORD_W-1:0] result_o
  , output logic                   cond_met_o
  , output flags_t                 flags_o
);

  localparam int W = `ARM_WORD_W;

  logic [W-1:0] add_x;
  logic [W-1:0] add_y;
  logic         add_cin;
  logic         arith;
  logic [W:0]   sum;
  logic         ovf;
  logic [W-1:0] logic_res;
  flags_t       flags_d;

  // ************************************************************************
  // Adder operands, subtraction as x + ~y + 1 so C is the inverted borrow
  // ************************************************************************
  always_comb begin
    add_x   = a_i;
    add_y   = b_i;
    add_cin = 1'b0;
    arith   = 1'b1;
    case (op_i)
      OP_SUB, OP_CMP: begin
        add_y   = ~b_i;
        add_cin = 1'b1;
      end
      OP_RSB: begin
        add_x   = b_i;
        add_y   = ~a_i;
        add_cin = 1'b1;
      end
      OP_ADD, OP_CMN: add_cin = 1'b0;
      OP_ADC: add_cin = flags_o.c;
      OP_SBC: begin
        add_y   = ~b_i;
        add_cin = flags_o.c;
      end
      OP_RSC: begin
        add_x   = b_i;
        add_y   = ~a_i;
        add_cin = flags_o.c;
      end
      default: arith = 1'b0;
    endcase
  end

  assign sum = {1'b0, add_x} + {1'b0, add_y} + {{W{1'b0}}, add_cin};
  assign ovf = (add_x[W-1] == add_y[W-1]) && (sum[W-1] != add_x[W-1]);

  always_comb begin
    case (op_i)
      OP_AND, OP_TST: logic_res = a_i & b_i;
      OP_EOR, OP_TEQ: logic_res = a_i ^ b_i;
      OP_ORR:         logic_res = a_i | b_i;
      OP_MOV:         logic_res = b_i;
      OP_BIC:         logic_res = a_i & ~b_i;
      OP_MVN:         logic_res = ~b_i;
      default:        logic_res = '0;
    endcase
  end

  assign result_o = arith ? sum[W-1:0] : logic_res;

  // Logical ops keep C and V
  assign flags_d.n = result_o[W-1];
  assign flags_d.z = (result_o == '0);
  assign flags_d.c = arith ? sum[W] : flags_o.c;
  assign flags_d.v = arith ? ovf : flags_o.v;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flags_o <= '0;
    end else if (set_flags_i) begin
      flags_o <= flags_d;
    end
  end

  // ************************************************************************
  // Condition check against the current flags
  // ************************************************************************
  always_comb begin
    case (cond_i)
      COND_EQ: cond_met_o = flags_o.z;
      COND_NE: cond_met_o = !flags_o.z;
      COND_CS: cond_met_o = flags_o.c;
      COND_CC: cond_met_o = !flags_o.c;
      COND_MI: cond_met_o = flags_o.n;
      COND_PL: cond_met_o = !flags_o.n;
      COND_VS: cond_met_o = flags_o.v;
      COND_VC: cond_met_o = !flags_o.v;
      COND_HI: cond_met_o = flags_o.c && !flags_o.z;
      COND_LS: cond_met_o = !flags_o.c || flags_o.z;
      COND_GE: cond_met_o = (flags_o.n == flags_o.v);
      COND_LT: cond_met_o = (flags_o.n != flags_o.v);
      COND_GT: cond_met_o = !flags_o.z && (flags_o.n == flags_o.v);
      COND_LE: cond_met_o = flags_o.z || (flags_o.n != flags_o.v);
      COND_AL: cond_met_o = 1'b1;
      default: cond_met_o = 1'b0;
    endcase
  end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`include "arm_exec_config.svh"

module reg_file import arm_pkg::*; (
    input  logic                   clk_i
  , input  logic                   reset_i
  , input  reg_addr_t              ra_addr_i
  , input  reg_addr_t              rb_addr_i
  , output logic [`ARM_WORD_W-1:0] ra_data_o
  , output logic [`ARM_WORD_W-1:0] rb_data_o
  , input  wb_t                    wb_i
);

  logic [`ARM_WORD_W-1:0] regs [`ARM_NUM_REGS];

  // Plain reads, execute forwards in-flight results
  assign ra_data_o = regs[ra_addr_i];
  assign rb_data_o = regs[rb_addr_i];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `ARM_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.en) begin
      regs[wb_i.addr] <= wb_i.data;
    end
  end

endmodule

// ==== source/execute.sv ====
`timescale 1ns/1ps
`include "arm_exec_config.svh"

module execute import arm_pkg::*; (
    input  logic                   clk_i
  , input  logic                   reset_i
  , input  ex_req_t                req_i
  , input  wb_t                    wb_i
  , output ex_res_t                res_o
  , output flags_t                 flags_o
  , output logic                   stall_o
  , output logic                   branch_o
  , output logic [`ARM_WORD_W-1:0] branch_off_o
  , output logic                   flush_o
);

  localparam int W = `ARM_WORD_W;

  logic [W-1:0] inst_word;
  inst_class_e  cls;
  logic         is_dp;
  logic         is_ls;
  logic         is_load_op;
  logic         ra_used;
  logic         rb_used;
  logic         writes_rd;
  logic [W-1:0] ra_val;
  logic [W-1:0] rb_val;
  logic [W-1:0] op2;
  logic [W-1:0] alu_result;
  alu_op_e      alu_op;
  logic         cond_met;
  logic         accept;
  logic         set_flags;
  ex_res_t      res_d;

  // Newest value wins: execute result, then write-back, then register file
  function automatic logic [W-1:0] fwd(input reg_addr_t addr, input logic [W-1:0] rf_data);
    if (res_o.do_write && res_o.rd == addr) begin
      return res_o.result;
    end else if (wb_i.en && wb_i.addr == addr) begin
      return wb_i.data;
    end
    return rf_data;
  endfunction

  function automatic logic load_hit(input reg_addr_t addr);
    return res_o.is_load && res_o.do_write && (res_o.rd == addr);
  endfunction

  assign inst_word  = req_i.inst;
  assign cls        = req_i.inst.dp.cls;
  assign is_dp      = (cls == CLS_DP_REG) || (cls == CLS_DP_IMM);
  assign is_ls      = (cls == CLS_LS);
  assign is_load_op = is_ls && req_i.inst.ls.l;

  // MOV and MVN ignore rn
  assign ra_used = is_ls || (is_dp && req_i.inst.dp.opcode != OP_MOV
                             && req_i.inst.dp.opcode != OP_MVN);
  assign rb_used = (cls == CLS_DP_REG) || (is_ls && !req_i.inst.ls.l);

  assign ra_val = fwd(req_i.ra_addr, req_i.ra_data);
  assign rb_val = fwd(req_i.rb_addr, req_i.rb_data);

  // ************************************************************************
  // Hazard, branch and flush strobes
  // ************************************************************************
  assign stall_o = req_i.valid && !flush_o
                   && ((ra_used && load_hit(req_i.ra_addr))
                       || (rb_used && load_hit(req_i.rb_addr)));

  assign accept   = req_i.valid && !stall_o && !flush_o;
  assign branch_o = accept && (cls == CLS_BRANCH) && cond_met;

  // Word offset, sign-extended from 24 bits
  assign branch_off_o = {{(W-24){inst_word[23]}}, inst_word[23:0]};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flush_o <= 1'b0;
    end else begin
      flush_o <= branch_o;
    end
  end

  // ************************************************************************
  // Operands and ALU
  // ************************************************************************
  assign alu_op    = is_ls ? (req_i.inst.ls.u ? OP_ADD : OP_SUB) : req_i.inst.dp.opcode;
  assign set_flags = accept && is_dp && req_i.inst.dp.s && cond_met;

  operand_unit u_operand_unit (
      .inst_i ( req_i.inst )
    , .rm_i   ( rb_val     )
    , .op2_o  ( op2        )
  );

  alu u_alu (
      .clk_i       ( clk_i               )
    , .reset_i     ( reset_i             )
    , .op_i        ( alu_op              )
    , .a_i         ( ra_val              )
    , .b_i         ( op2                 )
    , .cond_i      ( req_i.inst.dp.cond  )
    , .set_flags_i ( set_flags           )
    , .result_o    ( alu_result          )
    , .cond_met_o  ( cond_met            )
    , .flags_o     ( flags_o             )
  );

  // Compare opcodes only touch flags
  assign writes_rd = (is_dp && !(req_i.inst.dp.opcode inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN}))
                     || is_load_op;

  assign res_d.valid      = accept;
  assign res_d.do_write   = accept && cond_met && writes_rd;
  assign res_d.is_load    = accept && cond_met && is_load_op;
  assign res_d.is_store   = accept && cond_met && is_ls && !req_i.inst.ls.l;
  assign res_d.rd         = req_i.inst.dp.rd;
  assign res_d.result     = alu_result;
  assign res_d.store_data = rb_val;

  // Pipeline register, control bits cleared on reset
  always_ff @(posedge clk_i) begin
    res_o <= res_d;
    if (reset_i) begin
      res_o.valid    <= 1'b0;
      res_o.do_write <= 1'b0;
      res_o.is_load  <= 1'b0;
      res_o.is_store <= 1'b0;
    end
  end

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps
`include "arm_exec_config.svh"

module mem_stage import arm_pkg::*; (
    input  logic    clk_i
  , input  logic    reset_i
  , input  ex_res_t res_i
  , output wb_t     wb_o
);

  localparam int AW = $clog2(`ARM_DMEM_WORDS);

  logic [`ARM_WORD_W-1:0] dmem [`ARM_DMEM_WORDS];
  logic [AW-1:0]          word_addr;
  logic [`ARM_WORD_W-1:0] load_data;

  // Word aligned, low two bits dropped
  assign word_addr = res_i.result[AW+1:2];
  assign load_data = dmem[word_addr];

  always_ff @(posedge clk_i) begin
    if (res_i.valid && res_i.is_store) begin
      dmem[word_addr] <= res_i.store_data;
    end
  end

  // Write-back register
  always_ff @(posedge clk_i) begin
    wb_o.addr <= res_i.rd;
    wb_o.data <= res_i.is_load ? load_data : res_i.result;
    if (reset_i) begin
      wb_o.en <= 1'b0;
    end else begin
      wb_o.en <= res_i.valid && res_i.do_write;
    end
  end

endmodule

// ==== source/arm_exec_top.sv ====
`timescale 1ns/1ps
`include "arm_exec_config.svh"

module arm_exec_top import arm_pkg::*; (
    input  logic                   clk_i
  , input  logic                   reset_i
  , input  arm_inst_u              inst_i
  , input  logic                   valid_i
  , output logic                   stall_o
  , output logic                   branch_o
  , output logic                   flush_o
  , output logic [`ARM_WORD_W-1:0] branch_off_o
  , output wb_t                    wb_o
  , output flags_t                 flags_o
);

  reg_addr_t              ra_addr;
  reg_addr_t              rb_addr;
  logic [`ARM_WORD_W-1:0] ra_data;
  logic [`ARM_WORD_W-1:0] rb_data;
  ex_req_t                ex_req;
  ex_res_t                ex_res;

  // Port B reads rd for stores, rm otherwise
  assign ra_addr = inst_i.dp.rn;
  assign rb_addr = (inst_i.ls.cls == CLS_LS) ? inst_i.ls.rd : inst_i.dp.operand[3:0];

  assign ex_req = '{valid: valid_i, inst: inst_i, ra_data: ra_data, rb_data: rb_data,
                    ra_addr: ra_addr, rb_addr: rb_addr};

  reg_file u_reg_file (
      .clk_i     ( clk_i   )
    , .reset_i   ( reset_i )
    , .ra_addr_i ( ra_addr )
    , .rb_addr_i ( rb_addr )
    , .ra_data_o ( ra_data )
    , .rb_data_o ( rb_data )
    , .wb_i      ( wb_o    )
  );

  execute u_execute (
      .clk_i        ( clk_i        )
    , .reset_i      ( reset_i      )
    , .req_i        ( ex_req       )
    , .wb_i         ( wb_o         )
    , .res_o        ( ex_res       )
    , .flags_o      ( flags_o      )
    , .stall_o      ( stall_o      )
    , .branch_o     ( branch_o     )
    , .branch_off_o ( branch_off_o )
    , .flush_o      ( flush_o      )
  );

  mem_stage u_mem_stage (
      .clk_i   ( clk_i   )
    , .reset_i ( reset_i )
    , .res_i   ( ex_res  )
    , .wb_o    ( wb_o    )
  );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
  end

  always #50 clk_o = ~clk_o;

endmodule

// ==== bench/arm_exec_tb.sv ====
`timescale 1ns/1ps

module arm_exec_tb import arm_pkg::*; ();

  localparam logic [3:0] AL = 4'he;

  typedef struct packed {
    logic [3:0]  addr;
    logic [31:0] data;
    logic [31:0] cycle;
  } exp_wb_t;

  logic        clk;
  logic        reset_i;
  arm_inst_u   inst_i;
  logic        valid_i;
  logic        stall_o;
  logic        branch_o;
  logic        flush_o;
  logic [31:0] branch_off_o;
  wb_t         wb_o;
  flags_t      flags_o;

  logic [31:0] prog [$];
  exp_wb_t     exp_q [$];
  logic [31:0] ref_regs [16];
  logic [31:0] ref_mem [64];
  logic [3:0]  ref_flags;
  logic        ref_taken;
  logic        ref_load;
  logic [31:0] rng_state;
  logic [31:0] cycle;

  tb_clock u_clock (.clk_o(clk));

  arm_exec_top u_dut (
      .clk_i        ( clk          )
    , .reset_i      ( reset_i      )
    , .inst_i       ( inst_i       )
    , .valid_i      ( valid_i      )
    , .stall_o      ( stall_o      )
    , .branch_o     ( branch_o     )
    , .flush_o      ( flush_o      )
    , .branch_off_o ( branch_off_o )
    , .wb_o         ( wb_o         )
    , .flags_o      ( flags_o      )
  );

  // ************************************************************************
  // Failure reporting and value compare
  // ************************************************************************
  task automatic report_failure(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      report_failure("check failed");
    end
  endtask

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] enc_dpi(input logic [3:0] cnd, input logic [3:0] op,
      input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rot,
      input logic [7:0] imm8);
    return {cnd, 3'b001, op, s, rn, rd, rot, imm8};
  endfunction

  function automatic logic [31:0] enc_dpr(input logic [3:0] cnd, input logic [3:0] op,
      input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [4:0] sh,
      input logic [1:0] typ, input logic [3:0] rm);
    return {cnd, 3'b000, op, s, rn, rd, sh, typ, 1'b0, rm};
  endfunction

  function automatic logic [31:0] enc_ls(input logic l, input logic u, input logic [3:0] rn,
      input logic [3:0] rd, input logic [11:0] off);
    return {AL, 3'b010, 1'b1, u, 1'b0, 1'b0, l, rn, rd, off};
  endfunction

  function automatic logic [31:0] enc_b(input logic [3:0] cnd, input logic [23:0] off);
    return {cnd, 3'b101, 1'b0, off};
  endfunction

  // ************************************************************************
  // Reference model of registers, flags and data memory
  // ************************************************************************
  function automatic logic cond_holds(input logic [3:0] c);
    logic n;
    logic z;
    logic cf;
    logic v;
    {n, z, cf, v} = ref_flags;
    case (c)
      4'd0:  return z;
      4'd1:  return !z;
      4'd2:  return cf;
      4'd3:  return !cf;
      4'd4:  return n;
      4'd5:  return !n;
      4'd6:  return v;
      4'd7:  return !v;
      4'd8:  return cf && !z;
      4'd9:  return !cf || z;
      4'd10: return n == v;
      4'd11: return n != v;
      4'd12: return !z && (n == v);
      4'd13: return z || (n != v);
      4'd14: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] operand2(input logic [31:0] ins);
    logic [31:0] rm;
    logic [31:0] imm;
    int          sh;
    if (ins[25]) begin
      imm = {24'b0, ins[7:0]};
      sh  = 2 * int'(ins[11:8]);
      return (sh == 0) ? imm : ((imm >> sh) | (imm << (32 - sh)));
    end
    rm = ref_regs[ins[3:0]];
    sh = int'(ins[11:7]);
    case (ins[6:5])
      2'b00:   return rm << sh;
      2'b01:   return (sh == 0) ? 32'h0 : rm >> sh;
      2'b10:   return (sh == 0) ? {32{rm[31]}} : 32'($signed(rm) >>> sh);
      default: return (sh == 0) ? rm : ((rm >> sh) | (rm << (32 - sh)));
    endcase
  endfunction

  // Returns {C, V, result}
  function automatic logic [33:0] add_ref(input logic [31:0] x, input logic [31:0] y,
      input logic cin);
    logic [32:0] t;
    t = {1'b0, x} + {1'b0, y} + {32'b0, cin};
    return {t[32], (x[31] == y[31]) && (t[31] != x[31]), t[31:0]};
  endfunction

  // Carry is the inverted borrow and a low cin borrows one
  function automatic logic [33:0] sub_ref(input logic [31:0] x, input logic [31:0] y,
      input logic cin);
    logic [32:0] t;
    t = {1'b0, x} - {1'b0, y} - {32'b0, !cin};
    return {!t[32], (x[31] != y[31]) && (t[31] != x[31]), t[31:0]};
  endfunction

  function automatic wb_t ref_exec(input logic [31:0] ins);
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [33:0] cvr;
    wb_t         w;
    op = ins[24:21];
    rd = ins[15:12];
    a  = ref_regs[ins[19:16]];
    w  = '0;
    ref_taken = 1'b0;
    ref_load  = 1'b0;
    if (!cond_holds(ins[31:28])) begin
      return w;
    end
    if (ins[27:25] == 3'b101) begin
      ref_taken = 1'b1;
    end else if (ins[27:25] == 3'b010) begin
      addr = ins[23] ? a + {20'b0, ins[11:0]} : a - {20'b0, ins[11:0]};
      if (ins[20]) begin
        ref_load = 1'b1;
        ref_regs[rd] = ref_mem[addr[7:2]];
        w = '{en: 1'b1, addr: rd, data: ref_regs[rd]};
      end else begin
        ref_mem[addr[7:2]] = ref_regs[rd];
      end
    end else begin
      b   = operand2(ins);
      cvr = {ref_flags[1:0], 32'h0};
      case (op)
        4'd0, 4'd8:  cvr[31:0] = a & b;
        4'd1, 4'd9:  cvr[31:0] = a ^ b;
        4'd2, 4'd10: cvr = sub_ref(a, b, 1'b1);
        4'd3:        cvr = sub_ref(b, a, 1'b1);
        4'd4, 4'd11: cvr = add_ref(a, b, 1'b0);
        4'd5:        cvr = add_ref(a, b, ref_flags[1]);
        4'd6:        cvr = sub_ref(a, b, ref_flags[1]);
        4'd7:        cvr = sub_ref(b, a, ref_flags[1]);
        4'd12:       cvr[31:0] = a | b;
        4'd13:       cvr[31:0] = b;
        4'd14:       cvr[31:0] = a & ~b;
        default:     cvr[31:0] = ~b;
      endcase
      if (ins[20]) begin
        ref_flags = {cvr[31], cvr[31:0] == 32'h0, cvr[33], cvr[32]};
      end
      if (op < 4'd8 || op > 4'd11) begin
        ref_regs[rd] = cvr[31:0];
        w = '{en: 1'b1, addr: rd, data: cvr[31:0]};
      end
    end
    return w;
  endfunction

  // True when the instruction reads register r
  function automatic logic reads_reg(input logic [31:0] ins, input logic [3:0] r);
    logic rn_hit;
    rn_hit = (ins[19:16] == r);
    case (ins[27:25])
      3'b000:  return (rn_hit && ins[24:21] != 4'd13 && ins[24:21] != 4'd15) || ins[3:0] == r;
      3'b001:  return rn_hit && ins[24:21] != 4'd13 && ins[24:21] != 4'd15;
      3'b010:  return rn_hit || (!ins[20] && ins[15:12] == r);
      default: return 1'b0;
    endcase
  endfunction

  task automatic build_program();
    logic [31:0] r;
    for (int i = 1; i <= 8; i++) begin
      r = xorshift();
      prog.push_back(enc_dpi(AL, 4'd13, 1'b0, 4'd0, 4'(i), r[11:8], r[7:0]));
    end
    // Every opcode twice with random shifts, flags and conditions
    for (int i = 0; i < 32; i++) begin
      r = xorshift();
      prog.push_back(enc_dpr((r[31:30] == 2'b00) ? 4'(r[29:26] % 15) : AL, 4'(i % 16),
                             r[0], 4'(r[3:1] + 1), 4'(r[7:4] % 12 + 1), r[12:8],
                             r[14:13], 4'(r[17:15] + 1)));
    end
    // Dependent chain through both forwarding paths
    prog.push_back(enc_dpr(AL, 4'd4, 1'b1, 4'd1, 4'd2, 5'd0, 2'b00, 4'd1));
    prog.push_back(enc_dpr(AL, 4'd4, 1'b1, 4'd2, 4'd3, 5'd0, 2'b00, 4'd2));
    prog.push_back(enc_dpr(AL, 4'd2, 1'b1, 4'd3, 4'd4, 5'd3, 2'b10, 4'd2));
    prog.push_back(enc_dpi(4'd0, 4'd13, 1'b0, 4'd0, 4'd5, 4'd0, 8'h11));
    prog.push_back(enc_dpi(4'd1, 4'd13, 1'b0, 4'd0, 4'd6, 4'd0, 8'h22));
    // Store, load and a dependent use after each load
    prog.push_back(enc_dpi(AL, 4'd13, 1'b0, 4'd0, 4'd13, 4'd0, 8'h40));
    prog.push_back(enc_ls(1'b0, 1'b1, 4'd13, 4'd1, 12'd8));
    prog.push_back(enc_ls(1'b1, 1'b1, 4'd13, 4'd7, 12'd8));
    prog.push_back(enc_dpr(AL, 4'd4, 1'b0, 4'd7, 4'd8, 5'd0, 2'b00, 4'd7));
    prog.push_back(enc_ls(1'b0, 1'b0, 4'd13, 4'd2, 12'd4));
    prog.push_back(enc_ls(1'b1, 1'b0, 4'd13, 4'd9, 12'd4));
    prog.push_back(enc_dpr(AL, 4'd4, 1'b0, 4'd1, 4'd10, 5'd0, 2'b00, 4'd9));
    // Forward branch, backward branch to the MOVS, then the same BEQ failing
    prog.push_back(enc_dpr(AL, 4'd10, 1'b1, 4'd1, 4'd0, 5'd0, 2'b00, 4'd1));
    prog.push_back(enc_b(AL, 24'd2));
    prog.push_back(enc_dpi(AL, 4'd13, 1'b0, 4'd0, 4'd11, 4'd0, 8'h01));
    prog.push_back(enc_dpi(AL, 4'd13, 1'b1, 4'd0, 4'd11, 4'd0, 8'h02));
    prog.push_back(enc_dpi(AL, 4'd13, 1'b0, 4'd0, 4'd12, 4'd0, 8'h03));
    prog.push_back(enc_b(4'd0, 24'hfffffd));
    prog.push_back(enc_dpi(AL, 4'd13, 1'b0, 4'd0, 4'd11, 4'd0, 8'h04));
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ************************************************************************
  // Write-back compare
  // ************************************************************************
  always @(negedge clk) begin : compare_wb
    exp_wb_t e;
    if (!reset_i) begin
      if (wb_o.en) begin
        if (exp_q.size() == 0) begin
          report_failure("write-back seen with none expected");
        end else begin
          e = exp_q.pop_front();
          check("wb_o cycle", cycle, e.cycle);
          check("wb_o.addr", {28'b0, wb_o.addr}, {28'b0, e.addr});
          check("wb_o.data", wb_o.data, e.data);
        end
      end else if (exp_q.size() != 0 && exp_q[0].cycle <= cycle) begin
        report_failure("expected write-back did not appear");
      end
    end
  end

  initial begin : watchdog
    #1;
    repeat (20 * prog.size() + 100) @(posedge clk);
    report_failure("timeout waiting for the program to retire");
  end

  initial begin : stimulus
    int          pc;
    int          target;
    int          off;
    logic        pend;
    logic        load_prev;
    logic [3:0]  load_rd;
    logic [31:0] ins;
    wb_t         w;
    rng_state  = 32'hc2a8e029;
    cycle      = '0;
    ref_flags  = '0;
    for (int i = 0; i < 16; i++) begin
      ref_regs[i] = '0;
    end
    build_program();
    reset_i = 1'b1;
    valid_i = 1'b0;
    inst_i  = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_i   = 1'b0;
    pc        = 0;
    target    = 0;
    pend      = 1'b0;
    load_prev = 1'b0;
    load_rd   = '0;
    while (pc < prog.size()) begin
      @(negedge clk);
      check("flags_o", {28'b0, flags_o}, {28'b0, ref_flags});
      check("flush_o", {31'b0, flush_o}, {31'b0, pend});
      ins     = prog[pc];
      inst_i  = ins;
      valid_i = 1'b1;
      if (pend) begin
        // Wrong-path instruction that the flush discards
        pc        = target;
        pend      = 1'b0;
        load_prev = 1'b0;
        continue;
      end
      #1;
      check("stall_o", {31'b0, stall_o}, {31'b0, load_prev && reads_reg(ins, load_rd)});
      load_prev = 1'b0;
      if (!stall_o) begin
        w = ref_exec(ins);
        check("branch_o", {31'b0, branch_o}, {31'b0, ref_taken});
        if (ref_taken) begin
          off = int'($signed(ins[23:0]));
          check("branch_off_o", branch_off_o, 32'(off));
          pend   = 1'b1;
          target = pc + 1 + off;
        end
        if (w.en) begin
          exp_q.push_back('{addr: w.addr, data: w.data, cycle: cycle + 2});
        end
        load_prev = ref_load;
        load_rd   = ins[15:12];
        pc++;
      end
    end
    @(negedge clk);
    valid_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== arm_exec.f ====
+incdir+source
source/arm_pkg.sv
source/operand_unit.sv
source/alu.sv
source/reg_file.sv
source/execute.sv
source/mem_stage.sv
source/arm_exec_top.sv
bench/tb_clock.sv
bench/arm_exec_tb.sv

// ==== Makefile ====
TOP = arm_exec_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f arm_exec.f --top-module $(TOP)

sim:
	verilator --binary --timing -f arm_exec.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir
